/* Bender.yml */
package:
  name: rrag

export_include_dirs:
  - hw

sources:
  - hw/rrag_pkg.sv
  - hw/pipe_latch.sv
  - hw/gpr_file.sv
  - hw/seg_file.sv
  - hw/addr_gen.sv
  - hw/rrag.sv
  - hw/rrag_top.sv
  - target: test
    files:
      - tests/rrag_tb.sv

/* hw/addr_gen.sv */
`timescale 1ns/1ns

`include "rrag_consts.svh"

module addr_gen (
    input  logic [`RRAG_REG_W-1:0] base,
    input  logic                   use_base,
    input  logic [`RRAG_REG_W-1:0] index,
    input  logic                   use_idx,
    input  logic [1:0]             scale,
    input  logic [`RRAG_REG_W-1:0] disp,
    input  logic [`RRAG_SEG_W-1:0] seg_base,
    input  rrag_pkg::opsize_t      opsize,
    output logic [`RRAG_REG_W-1:0] lin_addr,
    output logic [`RRAG_REG_W-1:0] lin_end
);

    logic [`RRAG_REG_W-1:0] base_term;
    logic [`RRAG_REG_W-1:0] idx_term;
    logic [`RRAG_REG_W-1:0] seg_term;
    logic [`RRAG_REG_W-1:0] last_offs;

    assign base_term = use_base ? base : '0;
    assign idx_term  = use_idx ? (index << scale) : '0; // Scale of 1, 2, 4 or 8
    assign seg_term  = {{(`RRAG_REG_W - `RRAG_SEG_W){1'b0}}, seg_base} << `RRAG_SEG_SHIFT;

    // Sums wrap at the register width with the carry dropped
    assign lin_addr = base_term + idx_term + disp + seg_term;

    assign last_offs = (`RRAG_REG_W'(1) << opsize) - `RRAG_REG_W'(1); // Bytes past the first
    assign lin_end   = lin_addr + last_offs;

endmodule

/* hw/gpr_file.sv */
`timescale 1ns/1ns

`include "rrag_consts.svh"

module gpr_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  rrag_pkg::reg_addr_t [3:0]        rd_addr,    // Base is port 0 and the spare is port 3
    output logic [3:0][`RRAG_REG_W-1:0]      rd_data,
    output logic [3:0]                       rd_pending,
    input  logic                             wb_ld,
    input  rrag_pkg::reg_addr_t              wb_addr,
    input  logic [`RRAG_REG_W-1:0]           wb_data,
    input  logic                             set_ld,
    input  rrag_pkg::reg_addr_t              set_addr
);

    logic [`RRAG_REG_W-1:0] regs [`RRAG_NUM_GPR];
    logic [`RRAG_NUM_GPR-1:0] pending;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RRAG_NUM_GPR; i++) begin
                regs[i] <= '0; // Architectural state starts at zero
            end
        end else if (wb_ld) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // The set comes last so an issuing writer wins over a returning one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (wb_ld) begin
                pending[wb_addr] <= 1'b0;
            end
            if (set_ld) begin
                pending[set_addr] <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rd_data[p]    = regs[rd_addr[p]]; // Straight from the array with no bypass
            rd_pending[p] = pending[rd_addr[p]];
        end
    end

endmodule

/* hw/pipe_latch.sv */
`timescale 1ns/1ns

module pipe_latch #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid; // A bubble is captured like any other entry
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

endmodule

/* hw/rrag.sv */
`timescale 1ns/1ns

`include "rrag_consts.svh"

module rrag (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  rrag_pkg::uop_t    uop,
    input  rrag_pkg::wb_t     wb,
    input  logic              out_stall,
    output logic              valid_out,
    output rrag_pkg::rr_out_t result,
    output logic              stall
);

    logic [3:0][`RRAG_REG_W-1:0] gpr_data;
    logic [3:0]                  gpr_pending;
    logic [`RRAG_SEG_W-1:0]      seg_base;
    logic                        seg_pending;
    logic                        mem_use;
    logic                        hazard;
    logic                        gpr_set;
    logic                        seg_set;
    logic [`RRAG_REG_W-1:0]      lin_addr;
    logic [`RRAG_REG_W-1:0]      lin_end;

    gpr_file gprs (
        .clk(clk), .rst_n(rst_n),
        .rd_addr({uop.dest_addr, uop.src_addr, uop.idx_addr, uop.base_addr}),
        .rd_data(gpr_data), .rd_pending(gpr_pending),
        .wb_ld(wb.gpr_ld), .wb_addr(wb.gpr_addr), .wb_data(wb.gpr_data),
        .set_ld(gpr_set), .set_addr(uop.dest_addr)
    );

    seg_file segs (
        .clk(clk), .rst_n(rst_n),
        .rd_addr(uop.seg_addr), .rd_base(seg_base), .rd_pending(seg_pending),
        .wb_ld(wb.seg_ld), .wb_addr(wb.seg_addr), .wb_data(wb.seg_data),
        .set_ld(seg_set), .set_addr(uop.dest_addr)
    );

    addr_gen agen (
        .base(gpr_data[0]), .use_base(uop.use_base),
        .index(gpr_data[1]), .use_idx(uop.use_idx), .scale(uop.scale),
        .disp(uop.disp), .seg_base(seg_base), .opsize(uop.opsize),
        .lin_addr(lin_addr), .lin_end(lin_end)
    );

    // Only address inputs stall, a stale source goes on with its flag
    assign mem_use = |uop.mem_rw;
    assign hazard  = (uop.use_base & gpr_pending[0]) | (uop.use_idx & gpr_pending[1]) |
                     (mem_use & seg_pending);

    assign valid_out = in_valid & ~hazard & ~out_stall;
    assign stall     = out_stall | (in_valid & hazard);

    assign gpr_set = valid_out & uop.dest_ld & ~uop.dest_is_seg;
    assign seg_set = valid_out & uop.dest_ld & uop.dest_is_seg;

    always_comb begin
        result.lin_addr    = lin_addr;
        result.lin_end     = lin_end;
        result.src_data    = gpr_data[2];
        result.src_pending = gpr_pending[2];
        result.seg_base    = seg_base;
        result.dest_addr   = uop.dest_addr;
        result.dest_ld     = uop.dest_ld;
        result.dest_is_seg = uop.dest_is_seg;
        result.opsize      = uop.opsize;
        result.mem_rw      = uop.mem_rw;
        result.ctrl        = uop.ctrl;
    end

endmodule

/* hw/rrag_consts.svh */
`ifndef RRAG_CONSTS_SVH
`define RRAG_CONSTS_SVH

// Number of general registers; the segment file has the same count
`define RRAG_NUM_GPR 8

// General register and linear address width
`define RRAG_REG_W 32

// Segment base width
`define RRAG_SEG_W 16

// A segment base is aligned to this bit before it joins the address sum
`define RRAG_SEG_SHIFT 16

// Opaque control word carried through the stage
`define RRAG_CTRL_W 16

`endif

/* hw/rrag_pkg.sv */
`include "rrag_consts.svh"

package rrag_pkg;

    typedef logic [$clog2(`RRAG_NUM_GPR)-1:0] reg_addr_t; // Also indexes the segment file

    typedef logic [1:0] opsize_t; // Access is 1 << opsize bytes

    typedef struct packed {
        reg_addr_t              base_addr;
        logic                   use_base;
        reg_addr_t              idx_addr;
        logic                   use_idx;
        logic [1:0]             scale;       // Index is shifted left by this
        logic [`RRAG_REG_W-1:0] disp;
        reg_addr_t              seg_addr;
        reg_addr_t              src_addr;    // Data operand register
        reg_addr_t              dest_addr;
        logic                   dest_ld;
        logic                   dest_is_seg; // Destination lives in the segment file
        opsize_t                opsize;
        logic [1:0]             mem_rw;      // Bit 1 read and bit 0 write
        logic [`RRAG_CTRL_W-1:0] ctrl;
    } uop_t;

    typedef struct packed {
        logic                   gpr_ld;
        reg_addr_t              gpr_addr;
        logic [`RRAG_REG_W-1:0] gpr_data;
        logic                   seg_ld;
        reg_addr_t              seg_addr;
        logic [`RRAG_SEG_W-1:0] seg_data;
    } wb_t;

    typedef struct packed {
        logic [`RRAG_REG_W-1:0] lin_addr;
        logic [`RRAG_REG_W-1:0] lin_end;     // Address of the last byte touched
        logic [`RRAG_REG_W-1:0] src_data;
        logic                   src_pending; // Source value is stale and needs forwarding
        logic [`RRAG_SEG_W-1:0] seg_base;
        reg_addr_t              dest_addr;
        logic                   dest_ld;
        logic                   dest_is_seg;
        opsize_t                opsize;
        logic [1:0]             mem_rw;
        logic [`RRAG_CTRL_W-1:0] ctrl;
    } rr_out_t;

endpackage

/* hw/rrag_top.sv */
`timescale 1ns/1ns

module rrag_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  rrag_pkg::uop_t    in_uop,
    output logic              stall,
    input  rrag_pkg::wb_t     wb,
    input  logic              out_stall,
    output logic              out_valid,
    output rrag_pkg::rr_out_t out_data
);

    logic              stage_valid;
    rrag_pkg::uop_t    stage_uop;
    logic              rr_valid;
    rrag_pkg::rr_out_t rr_result;

    pipe_latch #(.payload_t(rrag_pkg::uop_t)) in_latch (
        .clk(clk), .rst_n(rst_n), .hold(stall),
        .in_valid(in_valid), .in_data(in_uop),
        .out_valid(stage_valid), .out_data(stage_uop)
    );

    rrag stage (
        .clk(clk), .rst_n(rst_n),
        .in_valid(stage_valid), .uop(stage_uop), .wb(wb), .out_stall(out_stall),
        .valid_out(rr_valid), .result(rr_result), .stall(stall)
    );

    // Takes a bubble on a hazard and freezes only for the next stage
    pipe_latch #(.payload_t(rrag_pkg::rr_out_t)) out_latch (
        .clk(clk), .rst_n(rst_n), .hold(out_stall),
        .in_valid(rr_valid), .in_data(rr_result),
        .out_valid(out_valid), .out_data(out_data)
    );

endmodule

/* hw/seg_file.sv */
`timescale 1ns/1ns

`include "rrag_consts.svh"

module seg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rrag_pkg::reg_addr_t    rd_addr,
    output logic [`RRAG_SEG_W-1:0] rd_base,
    output logic                   rd_pending,
    input  logic                   wb_ld,
    input  rrag_pkg::reg_addr_t    wb_addr,
    input  logic [`RRAG_SEG_W-1:0] wb_data,
    input  logic                   set_ld,
    input  rrag_pkg::reg_addr_t    set_addr
);

    localparam int NUM_SEG = 1 << $bits(rrag_pkg::reg_addr_t);

    logic [`RRAG_SEG_W-1:0] bases [NUM_SEG];
    logic [NUM_SEG-1:0] pending;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SEG; i++) begin
                bases[i] <= '0;
            end
            pending <= '0;
        end else begin
            if (wb_ld) begin
                bases[wb_addr]   <= wb_data;
                pending[wb_addr] <= 1'b0;
            end
            if (set_ld) begin
                pending[set_addr] <= 1'b1; // Overrides a clear in the same cycle
            end
        end
    end

    assign rd_base    = bases[rd_addr];
    assign rd_pending = pending[rd_addr];

endmodule

/* list.f */
+incdir+hw
hw/rrag_pkg.sv
hw/pipe_latch.sv
hw/gpr_file.sv
hw/seg_file.sv
hw/addr_gen.sv
hw/rrag.sv
hw/rrag_top.sv
tests/rrag_tb.sv

/* tests/rrag_tb.sv */
`timescale 1ns/1ns

`include "rrag_consts.svh"

module rrag_tb;

    localparam int RESET_CYCLES = 4;
    localparam int NUM_RAND     = 12;
    localparam int T_RESET      = 24;
    localparam int T_ADDR       = 8 + NUM_RAND + 8;
    localparam int T_HAZARD     = 24; // Each of the two hazard runs
    localparam int T_BACKP      = 20;
    localparam int MAX_CYCLES   = 2 * (T_RESET + T_ADDR + 2 * T_HAZARD + T_BACKP);

    logic              clk = 1'b0;
    logic              rst_n;
    logic              in_valid;
    rrag_pkg::uop_t    in_uop;
    logic              stall;
    rrag_pkg::wb_t     wb;
    logic              out_stall;
    logic              out_valid;
    rrag_pkg::rr_out_t out_data;

    logic [31:0]            lfsr = 32'h75fb1d0d;
    logic [`RRAG_REG_W-1:0] m_gpr [8];
    logic [`RRAG_SEG_W-1:0] m_seg [8];
    logic [7:0]             m_gpend;
    logic [7:0]             m_spend;
    rrag_pkg::rr_out_t      exp_q [$];
    rrag_pkg::rr_out_t      mon_exp;
    int                     errors = 0;
    int                     checks = 0;
    int                     cycles = 0;

    rrag_top UUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_uop(in_uop), .stall(stall),
        .wb(wb), .out_stall(out_stall), .out_valid(out_valid), .out_data(out_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic rrag_pkg::uop_t random_uop();
        rrag_pkg::uop_t u;
        u.base_addr = rand_bits(3);
        u.use_base = rand_bits(1);
        u.idx_addr = rand_bits(3);
        u.use_idx = rand_bits(1);
        u.scale = rand_bits(2);
        u.disp = rand_bits(32);
        u.seg_addr = rand_bits(3);
        u.src_addr = rand_bits(3);
        u.dest_addr = rand_bits(3);
        u.dest_ld = 1'b0; // Writers only where a test wants a pending register
        u.dest_is_seg = rand_bits(1);
        u.opsize = rand_bits(2);
        u.mem_rw = rand_bits(2);
        u.ctrl = rand_bits(16);
        return u;
    endfunction

    function automatic rrag_pkg::rr_out_t expected_result(input rrag_pkg::uop_t u);
        rrag_pkg::rr_out_t r;
        logic [31:0] sum;
        logic [31:0] size_bytes;
        sum = u.disp + {m_seg[u.seg_addr], 16'h0000};
        if (u.use_base) sum = sum + m_gpr[u.base_addr];
        if (u.use_idx) sum = sum + m_gpr[u.idx_addr] * (32'd1 << u.scale);
        case (u.opsize)
            2'd0: size_bytes = 1;
            2'd1: size_bytes = 2;
            2'd2: size_bytes = 4;
            default: size_bytes = 8;
        endcase
        r.lin_addr = sum;
        r.lin_end = sum + size_bytes - 1;
        r.src_data = m_gpr[u.src_addr];
        r.src_pending = m_gpend[u.src_addr];
        r.seg_base = m_seg[u.seg_addr];
        r.dest_addr = u.dest_addr;
        r.dest_ld = u.dest_ld;
        r.dest_is_seg = u.dest_is_seg;
        r.opsize = u.opsize;
        r.mem_rw = u.mem_rw;
        r.ctrl = u.ctrl;
        return r;
    endfunction

    // A used base or index, or the segment of a memory access, still waiting for writeback
    function automatic logic address_hazard(input rrag_pkg::uop_t u);
        logic h;
        h = 1'b0;
        if (u.use_base && m_gpend[u.base_addr]) h = 1'b1;
        if (u.use_idx && m_gpend[u.idx_addr]) h = 1'b1;
        if (u.mem_rw != 2'b00 && m_spend[u.seg_addr]) h = 1'b1;
        return h;
    endfunction

    task automatic check_eq(input logic [159:0] got, input logic [159:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // The next stage takes an entry on an edge where it is valid and not stalled
    always @(negedge clk) begin
        if (rst_n && out_valid && !out_stall) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected output at %0t ns with no micro-op outstanding", $time);
            end else begin
                mon_exp = exp_q.pop_front();
                check_eq({out_data.lin_addr, out_data.lin_end},
                         {mon_exp.lin_addr, mon_exp.lin_end}, "lin_addr and lin_end");
                check_eq({out_data.src_data, out_data.src_pending, out_data.seg_base},
                         {mon_exp.src_data, mon_exp.src_pending, mon_exp.seg_base},
                         "source data, pending flag and segment base");
                check_eq(out_data, mon_exp, "whole result with pass-through fields");
            end
        end
    end

    task automatic expect_uop(input rrag_pkg::uop_t u);
        exp_q.push_back(expected_result(u));
        if (u.dest_ld && u.dest_is_seg) m_spend[u.dest_addr] = 1'b1;
        if (u.dest_ld && !u.dest_is_seg) m_gpend[u.dest_addr] = 1'b1;
    endtask

    task automatic send_uop(input rrag_pkg::uop_t u);
        logic accepted;
        accepted = 1'b0;
        in_valid = 1'b1;
        in_uop = u;
        while (!accepted) begin
            @(negedge clk);
            accepted = !stall;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic issue_uop(input rrag_pkg::uop_t u);
        expect_uop(u);
        send_uop(u);
    endtask

    task automatic write_back(input logic is_seg, input logic [2:0] a, input logic [31:0] d);
        wb = '0;
        wb.gpr_ld = !is_seg;
        wb.gpr_addr = a;
        wb.gpr_data = d;
        wb.seg_ld = is_seg;
        wb.seg_addr = a;
        wb.seg_data = d[15:0];
        @(posedge clk);
        #1;
        wb = '0;
        if (is_seg) m_seg[a] = d[15:0];
        if (is_seg) m_spend[a] = 1'b0;
        if (!is_seg) m_gpr[a] = d;
        if (!is_seg) m_gpend[a] = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic reset_state();
        rrag_pkg::uop_t u;
        check_eq(out_valid, 1'b0, "out_valid after reset");
        check_eq(stall, 1'b0, "stall after reset");
        for (int i = 0; i < 8; i++) begin
            u = random_uop();
            u.base_addr = 3'(i);
            u.idx_addr = 3'(i);
            u.src_addr = 3'(i);
            u.seg_addr = 3'(i);
            issue_uop(u);
        end
        wait_drain();
    endtask

    task automatic address_sums();
        for (int i = 0; i < 8; i++) begin
            write_back(1'b0, 3'(i), rand_bits(32));
            write_back(1'b1, 3'(i), rand_bits(16));
        end
        repeat (NUM_RAND) issue_uop(random_uop());
        wait_drain();
    endtask

    task automatic hazard_pair(input logic is_seg);
        rrag_pkg::uop_t a;
        rrag_pkg::uop_t b;
        rrag_pkg::uop_t c;
        logic [2:0] r;
        r = rand_bits(3);
        a = random_uop();
        a.dest_ld = 1'b1;
        a.dest_is_seg = is_seg;
        a.dest_addr = r;
        b = random_uop();
        c = random_uop();
        if (is_seg) begin
            b.seg_addr = r;
            b.mem_rw = 2'b10;
            c.seg_addr = r;
            c.mem_rw = 2'b00; // No memory access, so the segment is not needed
        end else begin
            b.base_addr = r;
            b.use_base = 1'b1;
            c.src_addr = r;
            c.use_base = 1'b0;
            c.use_idx = 1'b0;
        end
        expect_uop(a);
        send_uop(a);
        send_uop(b);
        repeat (4) begin
            @(negedge clk);
            check_eq(stall, address_hazard(b), "stall while an address register is pending");
        end
        @(posedge clk);
        #1;
        write_back(is_seg, r, rand_bits(32));
        expect_uop(b);
        wait_drain();
        expect_uop(a);
        expect_uop(c);
        send_uop(a);
        send_uop(c);
        @(negedge clk);
        check_eq(stall, address_hazard(c),
                 "stall for a follower that needs no pending address register");
        @(posedge clk);
        #1;
        wait_drain();
        write_back(is_seg, r, rand_bits(32));
    endtask

    task automatic back_pressure();
        rrag_pkg::uop_t u [3];
        rrag_pkg::rr_out_t held;
        for (int i = 0; i < 3; i++) begin
            u[i] = random_uop();
            expect_uop(u[i]);
        end
        send_uop(u[0]);
        send_uop(u[1]);
        out_stall = 1'b1; // First result sits in the output latch, second in the stage
        fork
            send_uop(u[2]);
            begin
                @(negedge clk);
                check_eq(out_valid, 1'b1, "out_valid under out_stall");
                held = out_data;
                repeat (5) begin
                    @(negedge clk);
                    check_eq(out_data, held, "out_data under out_stall");
                    check_eq(stall, 1'b1, "stall under out_stall");
                end
                @(posedge clk);
                #1;
                out_stall = 1'b0;
            end
        join
        wait_drain();
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_uop = '0;
        wb = '0;
        out_stall = 1'b0;
        m_gpend = '0;
        m_spend = '0;
        for (int i = 0; i < 8; i++) begin
            m_gpr[i] = '0;
            m_seg[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state();
        address_sums();
        hazard_pair(1'b0);
        hazard_pair(1'b1);
        back_pressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
